//--- filelist.f
verilog/pcie_tlp_pkg.sv
verilog/tlp_rx_packer.sv
verilog/tlp_tx_splitter.sv
verilog/pcie_link_status.sv
verilog/pcie_tlp_bridge.sv
sim/pcie_tlp_bridge_assertions.sv
sim/pcie_tlp_bridge_tb.sv

//--- Bender.yml
package:
  name: pcie_tlp_bridge

sources:
  - verilog/pcie_tlp_pkg.sv
  - verilog/tlp_rx_packer.sv
  - verilog/tlp_tx_splitter.sv
  - verilog/pcie_link_status.sv
  - verilog/pcie_tlp_bridge.sv
  - target: test
    files:
      - sim/pcie_tlp_bridge_assertions.sv
      - sim/pcie_tlp_bridge_tb.sv

//--- sim/pcie_tlp_bridge_tb.sv
module pcie_tlp_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RX_PACKETS = 24;
    localparam int TX_BEATS = 40;
    // 40 cycles per packet or beat plus reset pulses and drain
    localparam int WATCHDOG_CYCLES = (RX_PACKETS + 2 + TX_BEATS) * 40 + 200;

    logic clk_pcie = 1'b0;
    logic rst, perst_n, user_reset, soft_rst, link_up, led_state;
    pcie_tlp_pkg::core_word_t   rx_data, tx_data;
    pcie_tlp_pkg::byte_keep_t   rx_keep, tx_keep;
    pcie_tlp_pkg::bar_hit_t     rx_bar_hit, rxs_bar_hit;
    pcie_tlp_pkg::stream_beat_t rxs_tdata, txs_tdata;
    pcie_tlp_pkg::dw_keep_t     rxs_tkeepdw, txs_tkeepdw;
    logic rx_last, rx_valid, rxs_tlast, rxs_tvalid, rxs_first;
    logic txs_tlast, txs_tvalid, txs_tready, tx_last, tx_valid, tx_ready;

    int unsigned n_err = 0;
    logic [31:0] seed = 32'h1e6bc03f;

    // Expected receive beats with unfilled dwords zero, and their dword counts
    pcie_tlp_pkg::stream_beat_t rx_exp_beat[$];
    int                         rx_exp_dws[$];
    pcie_tlp_pkg::core_word_t   tx_exp_word[$];

    pcie_tlp_bridge u_dut (.*);

    always #10 clk_pcie = ~clk_pcie;

    function automatic logic [31:0] rand32();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic compare_value(input string test, input logic [127:0] exp,
                                 input logic [127:0] act);
        if (exp !== act) begin
            n_err++;
            $display("ERR %s expected %h actual %h", test, exp, act);
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------

    // Full words followed by an optional one-dword tail word
    task automatic send_rx_packets(input int n);
        pcie_tlp_pkg::stream_beat_t model;
        int cnt;
        int words;
        int dws;
        logic odd_tail;
        model = '0;
        cnt = 0;
        for (int p = 0; p < n; p++) begin
            words = rand32() % 5 + 1;
            odd_tail = (rand32() % 2) == 1;
            for (int w = 0; w < words; w++) begin
                @(negedge clk_pcie);
                if (rand32() % 4 == 0) begin
                    rx_valid = 1'b0;
                    @(negedge clk_pcie);
                end
                dws = (odd_tail && w == words - 1) ? 1 : 2;
                rx_data = {rand32(), rand32()};
                rx_keep = (dws == 2) ? pcie_tlp_pkg::KEEP_TWO_DW : pcie_tlp_pkg::KEEP_ONE_DW;
                rx_last = (w == words - 1);
                rx_bar_hit = pcie_tlp_pkg::bar_hit_t'(rand32());
                rx_valid = 1'b1;
                for (int d = 0; d < dws; d++) begin
                    model[(cnt + d) * 32 +: 32] = rx_data[d * 32 +: 32];
                end
                cnt += dws;
                if (cnt > 2 || rx_last) begin
                    rx_exp_beat.push_back(model);
                    rx_exp_dws.push_back(cnt);
                    model = '0;
                    cnt = 0;
                end
            end
        end
        @(negedge clk_pcie);
        rx_valid = 1'b0;
    endtask

    // Starts and ends on a falling edge
    task automatic send_tx_beats(input int n);
        int ndw;
        logic done;
        for (int b = 0; b < n; b++) begin
            ndw = rand32() % 4 + 1;
            txs_tdata = {rand32(), rand32(), rand32(), rand32()};
            txs_tkeepdw = pcie_tlp_pkg::dw_keep_t'((1 << ndw) - 1);
            txs_tlast = (rand32() % 3 == 0) || (b == n - 1);
            txs_tvalid = 1'b1;
            tx_exp_word.push_back(txs_tdata[pcie_tlp_pkg::CORE_DATA_W-1:0]);
            if (ndw > 2) begin
                tx_exp_word.push_back(txs_tdata[127:pcie_tlp_pkg::CORE_DATA_W]);
            end
            done = 1'b0;
            while (!done) begin
                tx_ready = (rand32() % 4 != 0);
                @(posedge clk_pcie);
                done = txs_tready;
                @(negedge clk_pcie);
            end
        end
        txs_tvalid = 1'b0;
        tx_ready = 1'b1;
    endtask

    // 0 soft reset, 1 user reset, otherwise PERST#
    task automatic pulse_source(input int src);
        @(negedge clk_pcie);
        case (src)
            0: soft_rst = 1'b1;
            1: user_reset = 1'b1;
            default: perst_n = 1'b0;
        endcase
        // Traffic offered while the datapath is held in reset
        rx_data = {rand32(), rand32()};
        rx_keep = pcie_tlp_pkg::KEEP_TWO_DW;
        rx_last = 1'b0;
        rx_valid = 1'b1;
        txs_tvalid = 1'b1;
        repeat (2) @(negedge clk_pcie);
        soft_rst = 1'b0;
        user_reset = 1'b0;
        perst_n = 1'b1;
        rx_valid = 1'b0;
        txs_tvalid = 1'b0;
        repeat (4) @(negedge clk_pcie);
    endtask

    // --------------------
    // Scoreboards
    // --------------------

    always @(posedge clk_pcie) begin
        pcie_tlp_pkg::stream_beat_t mask;
        int dws;
        if (rxs_tvalid) begin
            if (rx_exp_beat.size() == 0) begin
                n_err++;
                $display("Receive beat appeared with no packet data pending");
            end else begin
                dws = rx_exp_dws.pop_front();
                mask = '0;
                for (int d = 0; d < dws; d++) begin
                    mask[d * 32 +: 32] = '1;
                end
                compare_value("rx_packing", rx_exp_beat.pop_front(), rxs_tdata & mask);
            end
        end
    end

    always @(posedge clk_pcie) begin
        if (tx_valid && tx_ready) begin
            if (tx_exp_word.size() == 0) begin
                n_err++;
                $display("Transmit word accepted with no beat pending");
            end else begin
                compare_value("tx_split", tx_exp_word.pop_front(), tx_data);
            end
        end
    end

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        rst = 1'b1;
        perst_n = 1'b1;
        user_reset = 1'b0;
        soft_rst = 1'b0;
        link_up = 1'b0;
        rx_data = '0;
        rx_keep = pcie_tlp_pkg::KEEP_TWO_DW;
        rx_last = 1'b0;
        rx_valid = 1'b0;
        rx_bar_hit = '0;
        txs_tdata = '0;
        txs_tkeepdw = '0;
        txs_tlast = 1'b0;
        txs_tvalid = 1'b0;
        tx_ready = 1'b1;
        repeat (3) @(posedge clk_pcie);
        @(negedge clk_pcie);
        rst = 1'b0;
        repeat (3) @(negedge clk_pcie);

        send_rx_packets(RX_PACKETS);
        send_tx_beats(TX_BEATS);
        pulse_source(0);
        pulse_source(1);
        pulse_source(2);
        // First marker again after the reset pulses
        send_rx_packets(2);
        link_up = 1'b1;
        repeat (4) @(negedge clk_pcie);
        link_up = 1'b0;
        repeat (5) @(negedge clk_pcie);

        if (rx_exp_beat.size() != 0) begin
            n_err++;
            $display("%0d expected receive beats never appeared", rx_exp_beat.size());
        end
        if (tx_exp_word.size() != 0) begin
            n_err++;
            $display("%0d expected transmit words never reached the core", tx_exp_word.size());
        end
        $display("Scoreboard errors: %0d, assertion failures: %0d",
                 n_err, u_dut.u_assertions.fail_cnt);
        if (n_err == 0 && u_dut.u_assertions.fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_pcie);
        $display("Watchdog expired before the test sequence finished");
        $display("test failed");
        $finish;
    end

endmodule

//--- sim/pcie_tlp_bridge_assertions.sv
module pcie_tlp_bridge_assertions (
    input logic                       clk_pcie,
    input logic                       rst_sub,
    input logic                       rst, perst_n, user_reset, soft_rst,
    input logic                       link_up, led_state,
    input pcie_tlp_pkg::byte_keep_t   rx_keep,
    input logic                       rx_last, rx_valid,
    input pcie_tlp_pkg::bar_hit_t     rx_bar_hit, rxs_bar_hit,
    input pcie_tlp_pkg::dw_keep_t     rxs_tkeepdw, txs_tkeepdw,
    input logic                       rxs_tlast, rxs_tvalid, rxs_first,
    input pcie_tlp_pkg::stream_beat_t txs_tdata,
    input logic                       txs_tlast, txs_tready,
    input pcie_tlp_pkg::core_word_t   tx_data,
    input pcie_tlp_pkg::byte_keep_t   tx_keep,
    input logic                       tx_last, tx_valid, tx_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;

    // --------------------
    // Receive shadow
    // --------------------

    logic [2:0]                sh_cnt;
    logic [2:0]                sh_sum;
    logic                      sh_emit;
    logic                      sh_last;
    logic                      sh_first;
    pcie_tlp_pkg::bar_hit_t    sh_bar;
    pcie_tlp_pkg::dw_keep_t    sh_mask;

    // Dwords in the beat once the incoming word lands
    assign sh_sum = (sh_emit ? 3'd0 : sh_cnt)
                  + ((rx_keep == pcie_tlp_pkg::KEEP_TWO_DW) ? 3'd2 : 3'd1);
    assign sh_mask = pcie_tlp_pkg::dw_keep_t'((1 << sh_cnt) - 1);

    always_ff @(posedge clk_pcie or posedge rst_sub) begin
        if (rst_sub) begin
            sh_cnt   <= '0;
            sh_emit  <= 1'b0;
            sh_first <= 1'b1;
        end else begin
            sh_emit <= rx_valid && (sh_sum > 3'd2 || rx_last);
            if (rx_valid) begin
                sh_cnt <= sh_sum;
            end else if (sh_emit) begin
                sh_cnt <= '0;
            end
            if (sh_emit) begin
                sh_first <= sh_last;
            end
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            sh_last <= rx_last;
            sh_bar  <= rx_bar_hit;
        end
    end

    // --------------------
    // Transmit shadow
    // --------------------

    logic                     sh_upper;
    logic                     tx_final;
    logic                     src_any;
    pcie_tlp_pkg::core_word_t exp_word;
    pcie_tlp_pkg::byte_keep_t exp_keep;

    assign tx_final = sh_upper || !txs_tkeepdw[2];
    assign exp_word = sh_upper ? txs_tdata[pcie_tlp_pkg::STREAM_DATA_W-1:pcie_tlp_pkg::CORE_DATA_W]
                               : txs_tdata[pcie_tlp_pkg::CORE_DATA_W-1:0];
    assign exp_keep = (sh_upper ? txs_tkeepdw[3] : txs_tkeepdw[1]) ? pcie_tlp_pkg::KEEP_TWO_DW
                                                                    : pcie_tlp_pkg::KEEP_ONE_DW;
    assign src_any = rst || !perst_n || user_reset || soft_rst;

    always_ff @(posedge clk_pcie or posedge rst_sub) begin
        if (rst_sub) begin
            sh_upper <= 1'b0;
        end else if (tx_valid && tx_ready) begin
            sh_upper <= !tx_final;
        end
    end

    // --------------------
    // Checks
    // --------------------

    a_rx_emit: assert property (@(posedge clk_pcie) disable iff (rst_sub)
        rxs_tvalid == sh_emit) else begin
        fail_cnt++;
        $error("Receive beat not emitted one cycle after its completing word");
    end
    a_rx_keep: assert property (@(posedge clk_pcie) disable iff (rst_sub)
        rxs_tvalid |-> rxs_tkeepdw == sh_mask && (rxs_tlast || rxs_tkeepdw[2])) else begin
        fail_cnt++;
        $error("Receive dword keep wrong or short non-last beat");
    end
    a_rx_marks: assert property (@(posedge clk_pcie) disable iff (rst_sub)
        rxs_tvalid |-> rxs_tlast == sh_last && rxs_first == sh_first && rxs_bar_hit == sh_bar)
        else begin
        fail_cnt++;
        $error("Receive last, first or BAR hit marker wrong");
    end
    a_tx_word: assert property (@(posedge clk_pcie) disable iff (rst_sub)
        tx_valid |-> tx_data == exp_word && tx_keep == exp_keep
                     && tx_last == (txs_tlast && tx_final)) else begin
        fail_cnt++;
        $error("Transmit word data, keep or last wrong");
    end
    a_tx_hold: assert property (@(posedge clk_pcie) disable iff (rst_sub)
        tx_valid && !tx_ready |=> $stable(tx_data) && $stable(tx_keep) && $stable(tx_last))
        else begin
        fail_cnt++;
        $error("Transmit word changed while stalled");
    end
    a_tx_ready: assert property (@(posedge clk_pcie) disable iff (rst_sub)
        txs_tready == (tx_valid && tx_ready && tx_final)) else begin
        fail_cnt++;
        $error("Stream ready not tied to the final word of the beat");
    end
    a_rst_on: assert property (@(posedge clk_pcie) src_any |-> rst_sub) else begin
        fail_cnt++;
        $error("Datapath reset not asserted by an active source");
    end
    a_rst_off: assert property (@(posedge clk_pcie)
        $fell(src_any) |-> rst_sub ##1 rst_sub ##1 !rst_sub) else begin
        fail_cnt++;
        $error("Datapath reset release not two cycles after sources cleared");
    end
    a_quiet: assert property (@(posedge clk_pcie) rst_sub |-> !rxs_tvalid && !tx_valid) else begin
        fail_cnt++;
        $error("Valid output high during datapath reset");
    end
    a_led: assert property (@(posedge clk_pcie) link_up |-> led_state) else begin
        fail_cnt++;
        $error("LED off while link is up");
    end

endmodule

bind pcie_tlp_bridge pcie_tlp_bridge_assertions u_assertions (.*);

//--- verilog/pcie_tlp_bridge.sv
module pcie_tlp_bridge (
    input  logic                        clk_pcie,
    input  logic                        rst,
    input  logic                        perst_n,
    input  logic                        user_reset,
    input  logic                        soft_rst,
    input  logic                        link_up,
    output logic                        led_state,

    // Core receive side
    input  pcie_tlp_pkg::core_word_t    rx_data,
    input  pcie_tlp_pkg::byte_keep_t    rx_keep,
    input  logic                        rx_last,
    input  logic                        rx_valid,
    input  pcie_tlp_pkg::bar_hit_t      rx_bar_hit,

    // Receive TLP stream
    output pcie_tlp_pkg::stream_beat_t  rxs_tdata,
    output pcie_tlp_pkg::dw_keep_t      rxs_tkeepdw,
    output logic                        rxs_tlast,
    output logic                        rxs_tvalid,
    output logic                        rxs_first,
    output pcie_tlp_pkg::bar_hit_t      rxs_bar_hit,

    // Transmit TLP stream
    input  pcie_tlp_pkg::stream_beat_t  txs_tdata,
    input  pcie_tlp_pkg::dw_keep_t      txs_tkeepdw,
    input  logic                        txs_tlast,
    input  logic                        txs_tvalid,
    output logic                        txs_tready,

    // Core transmit side
    output pcie_tlp_pkg::core_word_t    tx_data,
    output pcie_tlp_pkg::byte_keep_t    tx_keep,
    output logic                        tx_last,
    output logic                        tx_valid,
    input  logic                        tx_ready
);

    // Synchronized reset shared by both datapath directions
    logic rst_sub;

    // --------------------
    // Reset and status
    // --------------------

    pcie_link_status u_link_status (
        .clk_pcie    ( clk_pcie    ),
        .rst         ( rst         ),
        .perst_n     ( perst_n     ),
        .user_reset  ( user_reset  ),
        .soft_rst    ( soft_rst    ),
        .link_up     ( link_up     ),
        .rst_sub     ( rst_sub     ),
        .led_state   ( led_state   )
    );

    // --------------------
    // Receive path
    // --------------------

    tlp_rx_packer u_rx_packer (
        .clk_pcie    ( clk_pcie    ),
        .rst_sub     ( rst_sub     ),
        .rx_data     ( rx_data     ),
        .rx_keep     ( rx_keep     ),
        .rx_last     ( rx_last     ),
        .rx_valid    ( rx_valid    ),
        .rx_bar_hit  ( rx_bar_hit  ),
        .rxs_tdata   ( rxs_tdata   ),
        .rxs_tkeepdw ( rxs_tkeepdw ),
        .rxs_tlast   ( rxs_tlast   ),
        .rxs_tvalid  ( rxs_tvalid  ),
        .rxs_first   ( rxs_first   ),
        .rxs_bar_hit ( rxs_bar_hit )
    );

    // --------------------
    // Transmit path
    // --------------------

    tlp_tx_splitter u_tx_splitter (
        .clk_pcie    ( clk_pcie    ),
        .rst_sub     ( rst_sub     ),
        .txs_tdata   ( txs_tdata   ),
        .txs_tkeepdw ( txs_tkeepdw ),
        .txs_tlast   ( txs_tlast   ),
        .txs_tvalid  ( txs_tvalid  ),
        .txs_tready  ( txs_tready  ),
        .tx_data     ( tx_data     ),
        .tx_keep     ( tx_keep     ),
        .tx_last     ( tx_last     ),
        .tx_valid    ( tx_valid    ),
        .tx_ready    ( tx_ready    )
    );

endmodule

//--- verilog/pcie_link_status.sv
module pcie_link_status (
    input  logic clk_pcie,
    input  logic rst,
    input  logic perst_n,
    input  logic user_reset,
    input  logic soft_rst,
    input  logic link_up,
    output logic rst_sub,
    output logic led_state
);

    // --------------------
    // Datapath reset
    // --------------------

    // Any source holds the datapath in reset
    logic rst_any;

    // Synchronizer chain, shifts zeros in once all sources are quiet
    logic [pcie_tlp_pkg::RST_SYNC_STAGES-1:0] rst_pipe;

    assign rst_any = rst || !perst_n || user_reset || soft_rst;

    // Asserts at once, releases on clk_pcie
    always_ff @(posedge clk_pcie or posedge rst_any) begin
        if (rst_any) begin
            rst_pipe <= '1;
        end else begin
            rst_pipe <= {rst_pipe[pcie_tlp_pkg::RST_SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign rst_sub = rst_pipe[pcie_tlp_pkg::RST_SYNC_STAGES-1];

    // --------------------
    // Heartbeat and LED
    // --------------------

    logic [pcie_tlp_pkg::LED_BLINK_BIT:0] beat_cnt;

    always_ff @(posedge clk_pcie or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // Steady on with link, blinking without
    assign led_state = link_up || beat_cnt[pcie_tlp_pkg::LED_BLINK_BIT];

endmodule

//--- verilog/tlp_tx_splitter.sv
module tlp_tx_splitter (
    input  logic                        clk_pcie,
    input  logic                        rst_sub,

    // 128-bit beats from the user
    input  pcie_tlp_pkg::stream_beat_t  txs_tdata,
    input  pcie_tlp_pkg::dw_keep_t      txs_tkeepdw,
    input  logic                        txs_tlast,
    input  logic                        txs_tvalid,
    output logic                        txs_tready,

    // 64-bit words to the core
    output pcie_tlp_pkg::core_word_t    tx_data,
    output pcie_tlp_pkg::byte_keep_t    tx_keep,
    output logic                        tx_last,
    output logic                        tx_valid,
    input  logic                        tx_ready
);

    // --------------------
    // Phase
    // --------------------

    // Low while sending the lower half, high for the upper half
    logic phase_hi;

    // Beat spills into the upper half
    logic has_upper;
    // Current word carries two dwords
    logic word_two;
    // Current word is the last one of the beat
    logic final_word;
    // Core takes a word this cycle
    logic word_accept;

    assign has_upper   = txs_tkeepdw[pcie_tlp_pkg::CORE_DWORDS];
    assign word_accept = tx_valid && tx_ready;
    assign final_word  = phase_hi || !has_upper;

    always_comb begin
        if (phase_hi) begin
            word_two = txs_tkeepdw[pcie_tlp_pkg::STREAM_DWORDS-1];
        end else begin
            word_two = txs_tkeepdw[pcie_tlp_pkg::CORE_DWORDS-1];
        end
    end

    // Phase holds while the core stalls
    always_ff @(posedge clk_pcie or posedge rst_sub) begin
        if (rst_sub) begin
            phase_hi <= 1'b0;
        end else if (word_accept) begin
            if (!phase_hi && has_upper) begin
                phase_hi <= 1'b1;
            end else begin
                phase_hi <= 1'b0;
            end
        end
    end

    // --------------------
    // Core outputs
    // --------------------

    always_comb begin
        if (phase_hi) begin
            tx_data = txs_tdata[pcie_tlp_pkg::STREAM_DATA_W-1:pcie_tlp_pkg::CORE_DATA_W];
        end else begin
            tx_data = txs_tdata[pcie_tlp_pkg::CORE_DATA_W-1:0];
        end
    end

    always_comb begin
        if (word_two) begin
            tx_keep = pcie_tlp_pkg::KEEP_TWO_DW;
        end else begin
            tx_keep = pcie_tlp_pkg::KEEP_ONE_DW;
        end
    end

    assign tx_last  = txs_tlast && final_word;

    // No word is offered to the core during datapath reset
    assign tx_valid = txs_tvalid && !rst_sub;

    // Beat is released only together with its final word
    assign txs_tready = word_accept && final_word;

endmodule

//--- verilog/tlp_rx_packer.sv
module tlp_rx_packer (
    input  logic                        clk_pcie,
    input  logic                        rst_sub,

    // Core receive words, always accepted
    input  pcie_tlp_pkg::core_word_t    rx_data,
    input  pcie_tlp_pkg::byte_keep_t    rx_keep,
    input  logic                        rx_last,
    input  logic                        rx_valid,
    input  pcie_tlp_pkg::bar_hit_t      rx_bar_hit,

    // 128-bit beats, no back-pressure
    output pcie_tlp_pkg::stream_beat_t  rxs_tdata,
    output pcie_tlp_pkg::dw_keep_t      rxs_tkeepdw,
    output logic                        rxs_tlast,
    output logic                        rxs_tvalid,
    output logic                        rxs_first,
    output pcie_tlp_pkg::bar_hit_t      rxs_bar_hit
);

    // --------------------
    // State
    // --------------------

    // Dwords collected in the current beat, 0 to 4
    logic [$clog2(pcie_tlp_pkg::STREAM_DWORDS+1)-1:0] fill_cnt;
    // Dword offset where the incoming word lands
    logic [$clog2(pcie_tlp_pkg::STREAM_DWORDS+1)-1:0] fill_base;
    logic [$clog2(pcie_tlp_pkg::STREAM_DWORDS+1)-1:0] fill_next;
    // Dwords carried by the incoming word
    logic [$clog2(pcie_tlp_pkg::STREAM_DWORDS+1)-1:0] word_dws;

    logic                       last_q;
    logic                       first_q;
    logic                       beat_out;
    pcie_tlp_pkg::stream_beat_t beat_q;
    pcie_tlp_pkg::bar_hit_t     bar_hit_q;

    // --------------------
    // Fill arithmetic
    // --------------------

    // Beat goes out once it holds more than one core word, or at packet end
    assign beat_out = last_q || (fill_cnt > pcie_tlp_pkg::CORE_DWORDS);

    // A word arriving while a beat is out starts the next beat at dword 0
    assign fill_base = beat_out ? '0 : fill_cnt;

    always_comb begin
        if (rx_keep == pcie_tlp_pkg::KEEP_TWO_DW) begin
            word_dws = 2;
        end else begin
            word_dws = 1;
        end
    end

    assign fill_next = fill_base + word_dws;

    // --------------------
    // Control registers
    // --------------------

    always_ff @(posedge clk_pcie or posedge rst_sub) begin
        if (rst_sub) begin
            fill_cnt <= '0;
            last_q   <= 1'b0;
            first_q  <= 1'b1;
        end else begin
            // Next beat is a first beat only if this one closed a packet
            if (beat_out) begin
                first_q <= last_q;
            end

            if (rx_valid) begin
                fill_cnt <= fill_next;
                last_q   <= rx_last;
            end else if (beat_out) begin
                fill_cnt <= '0;
                last_q   <= 1'b0;
            end
        end
    end

    // Beat payload and BAR hit of the latest word
    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            beat_q[pcie_tlp_pkg::DW_WIDTH*fill_base +: pcie_tlp_pkg::CORE_DATA_W] <= rx_data;
            bar_hit_q <= rx_bar_hit;
        end
    end

    // --------------------
    // Stream outputs
    // --------------------

    // Filled dwords are contiguous from dword 0
    always_comb begin
        for (int i = 0; i < pcie_tlp_pkg::STREAM_DWORDS; i++) begin
            rxs_tkeepdw[i] = (fill_cnt > i);
        end
    end

    assign rxs_tdata   = beat_q;
    assign rxs_tlast   = last_q;
    assign rxs_tvalid  = beat_out;
    assign rxs_first   = first_q;
    assign rxs_bar_hit = bar_hit_q;

endmodule

//--- verilog/pcie_tlp_pkg.sv
package pcie_tlp_pkg;

    // --------------------
    // Datapath geometry
    // --------------------

    // Bits in one dword
    localparam int DW_WIDTH = 32;

    // Dwords per 64-bit core word and per 128-bit stream beat
    localparam int CORE_DWORDS = 2;
    localparam int STREAM_DWORDS = 4;

    localparam int CORE_DATA_W = CORE_DWORDS * DW_WIDTH;
    localparam int STREAM_DATA_W = STREAM_DWORDS * DW_WIDTH;

    // One keep bit per byte lane of a core word
    localparam int CORE_KEEP_W = CORE_DATA_W / 8;

    // BAR hit field as delivered by the core in its rx user bits
    localparam int BAR_HIT_W = 7;

    // --------------------
    // Reset and LED
    // --------------------

    localparam int RST_SYNC_STAGES = 2;

    // Roughly a 1 s blink period at 62.5 MHz
    localparam int LED_BLINK_BIT = 25;

    // --------------------
    // Types
    // --------------------

    typedef logic [CORE_DATA_W-1:0] core_word_t;
    typedef logic [STREAM_DATA_W-1:0] stream_beat_t;
    typedef logic [CORE_KEEP_W-1:0] byte_keep_t;
    typedef logic [STREAM_DWORDS-1:0] dw_keep_t;
    typedef logic [BAR_HIT_W-1:0] bar_hit_t;

    // Byte keep patterns of a core word
    // Low four lanes only
    localparam byte_keep_t KEEP_ONE_DW = 8'h0f;
    // All eight lanes
    localparam byte_keep_t KEEP_TWO_DW = 8'hff;

endpackage
